// File: source/ife_cfg.svh
`ifndef IFE_CFG_SVH
`define IFE_CFG_SVH

// Bytes in one memory line.
// Every request and reply moves a whole line.
`define IFE_LINE_BYTES 16

// Capacity of the fetched-byte buffer.
// Two full lines fit at once.
`define IFE_BUF_DEPTH 32

// Width of the buffer pop port, in bytes.
// The longest legal instruction is 6 bytes.
`define IFE_MAX_INST 8

// Line requests allowed in flight, stale ones included.
`define IFE_REQ_DEPTH 4

// Entries in the decoded instruction queue.
`define IFE_IQ_DEPTH 8

`endif

// File: source/ife_pkg.sv
`include "ife_cfg.svh"

package ife_pkg;

    // One instruction byte.
    typedef logic [7:0] byte_t;

    // Byte address in the instruction space.
    typedef logic [31:0] addr_t;

    // Instruction length in bytes, 0 means no instruction.
    typedef logic [3:0] inst_len_t;

    // Byte count in the buffer, holds 0 up to the full depth.
    typedef logic [$clog2(`IFE_BUF_DEPTH):0] buf_count_t;

    // One memory line, byte 0 in the lowest bits.
    typedef logic [`IFE_LINE_BYTES*8-1:0] line_data_t;

    // One bit per byte of a line.
    typedef logic [`IFE_LINE_BYTES-1:0] byte_mask_t;

    // Instruction bytes, first byte lowest, unused bytes zero.
    typedef logic [47:0] inst_bytes_t;

    // Line read request, address is line aligned.
    typedef struct packed {
        addr_t addr;
    } line_req_t;

    // Line read reply from memory.
    typedef struct packed {
        addr_t      addr;
        line_data_t data;
    } line_reply_t;

    // Decoded instruction as seen by the back end.
    typedef struct packed {
        inst_bytes_t bits;
        addr_t       addr;
        inst_len_t   len;
    } queued_inst_t;

endpackage

// File: source/line_fetcher.sv
`timescale 1ns/10ps
`include "ife_cfg.svh"

module line_fetcher (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  ife_pkg::addr_t       pc,
    output logic                 mem_req_present,
    output ife_pkg::line_req_t   mem_req,
    input  logic                 mem_req_taken,
    input  logic                 mem_reply_present,
    input  ife_pkg::line_reply_t mem_reply,
    input  ife_pkg::buf_count_t  buf_free,
    output ife_pkg::byte_mask_t  buf_push,
    output ife_pkg::line_data_t  buf_data
);
    // Pointer and count widths of the in-flight mask FIFO.
    localparam int PTR_W = $clog2(`IFE_REQ_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    // Byte offset within a line.
    localparam int OFS_W = $clog2(`IFE_LINE_BYTES);
    // Reserved bytes can reach four full lines.
    localparam int RSV_W = $clog2(`IFE_REQ_DEPTH * `IFE_LINE_BYTES) + 1;
    localparam int MB_W = OFS_W + 1;

    // Number of bytes set in a line mask.
    function automatic logic [MB_W-1:0] mask_bytes(ife_pkg::byte_mask_t m);
        logic [MB_W-1:0] n;
        n = '0;
        for (int i = 0; i < `IFE_LINE_BYTES; i++) begin
            n = n + MB_W'(m[i]);
        end
        return n;
    endfunction

    ife_pkg::addr_t      fetch_addr;
    ife_pkg::addr_t      line_addr;
    ife_pkg::addr_t      next_line;
    logic                fetch_enabled;
    ife_pkg::byte_mask_t mask_fifo [`IFE_REQ_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    mask_count;
    logic [CNT_W-1:0]    stale_count;
    logic [CNT_W-1:0]    in_flight;
    logic [RSV_W-1:0]    reserved;
    logic [RSV_W-1:0]    req_bytes;
    logic [RSV_W-1:0]    push_bytes;
    ife_pkg::byte_mask_t req_mask;
    logic                room_ok;
    logic                req_fire;
    logic                reply_live;
    logic                reply_stale;

    // Line holding the fetch address, and the one after it.
    assign line_addr = {fetch_addr[31:OFS_W], {OFS_W{1'b0}}};
    assign next_line = line_addr + ife_pkg::addr_t'(`IFE_LINE_BYTES);

    // Bytes below the fetch address are not wanted.
    // Only the first line after a jump has a nonzero offset.
    assign req_mask = {`IFE_LINE_BYTES{1'b1}} << fetch_addr[OFS_W-1:0];

    // Stale requests still occupy the memory pipe.
    assign in_flight = mask_count + stale_count;

    // Free space must cover every line already asked for, plus this one.
    assign room_ok = {1'b0, buf_free} >= reserved + RSV_W'(`IFE_LINE_BYTES);

    assign mem_req_present = fetch_enabled && (in_flight < `IFE_REQ_DEPTH) && room_ok;
    assign mem_req.addr    = line_addr;
    assign req_fire        = mem_req_present && mem_req_taken;

    // Replies come back in request order.
    // while stale ones are owed, the next reply is dropped
    assign reply_stale = mem_reply_present && (stale_count != '0);
    assign reply_live  = mem_reply_present && (stale_count == '0);

    // Live reply goes straight to the buffer under its recorded mask.
    assign buf_push = reply_live ? mask_fifo[rd_ptr] : '0;
    assign buf_data = mem_reply.data;

    assign req_bytes  = req_fire ? RSV_W'(mask_bytes(req_mask)) : '0;
    assign push_bytes = RSV_W'(mask_bytes(buf_push));

    // Holds requests off in the cycle after reset.
    always_ff @(posedge clk) begin
        fetch_enabled <= !reset;
    end

    // Mask storage.
    always_ff @(posedge clk) begin
        if (req_fire) begin
            mask_fifo[wr_ptr] <= req_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_addr  <= '0;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            mask_count  <= '0;
            stale_count <= '0;
            reserved    <= '0;
        end else if (flush) begin
            // Restart at the jump target.
            fetch_addr  <= pc;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            mask_count  <= '0;
            reserved    <= '0;
            // Everything still owed by memory is now stale.
            stale_count <= in_flight + CNT_W'(req_fire) - CNT_W'(mem_reply_present);
        end else begin
            if (req_fire) begin
                fetch_addr <= next_line;
                wr_ptr     <= wr_ptr + 1'b1;
            end
            if (reply_live) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (reply_stale) begin
                stale_count <= stale_count - 1'b1;
            end
            mask_count <= mask_count + CNT_W'(req_fire) - CNT_W'(reply_live);
            // Pushed bytes now show up in buf_free, so release them.
            reserved   <= reserved + req_bytes - push_bytes;
        end
    end

endmodule

// File: source/byte_buffer.sv
`timescale 1ns/10ps
`include "ife_cfg.svh"

module byte_buffer (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    flush,
    input  ife_pkg::byte_mask_t                     buf_push,
    input  ife_pkg::line_data_t                     buf_data,
    input  ife_pkg::inst_len_t                      buf_pop_len,
    output ife_pkg::byte_t [`IFE_MAX_INST-1:0]      buf_head,
    output ife_pkg::buf_count_t                     buf_count,
    output ife_pkg::buf_count_t                     buf_free
);
    // Byte 0 is the oldest byte.
    ife_pkg::byte_t [`IFE_BUF_DEPTH-1:0] bytes_q;
    ife_pkg::byte_t [`IFE_BUF_DEPTH-1:0] next_bytes;
    ife_pkg::buf_count_t                 count;
    ife_pkg::buf_count_t                 next_count;

    assign buf_head  = bytes_q[`IFE_MAX_INST-1:0];
    assign buf_count = count;
    assign buf_free  = ife_pkg::buf_count_t'(`IFE_BUF_DEPTH) - count;

    // Pop first, then append the pushed line.
    always_comb begin
        ife_pkg::buf_count_t fill;
        // Drop the popped bytes off the head.
        next_bytes = bytes_q >> {buf_pop_len, 3'b000};
        fill       = count - ife_pkg::buf_count_t'(buf_pop_len);
        // Masked bytes land in ascending order with no gaps.
        for (int i = 0; i < `IFE_LINE_BYTES; i++) begin
            if (buf_push[i]) begin
                if (fill < `IFE_BUF_DEPTH) begin
                    next_bytes[fill] = buf_data[i*8 +: 8];
                end
                fill = fill + 1'b1;
            end
        end
        next_count = fill;
    end

    // Byte storage.
    // Bytes past the count are don't-care.
    always_ff @(posedge clk) begin
        bytes_q <= next_bytes;
    end

    // A jump drops every byte held.
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            count <= '0;
        end else begin
            count <= next_count;
        end
    end

endmodule

// File: source/length_decoder.sv
`timescale 1ns/10ps
`include "ife_cfg.svh"

module length_decoder (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                flush,
    input  ife_pkg::addr_t                      pc,
    input  ife_pkg::byte_t [`IFE_MAX_INST-1:0]  buf_head,
    input  ife_pkg::buf_count_t                 buf_count,
    input  logic                                iq_full,
    output ife_pkg::inst_len_t                  buf_pop_len,
    output logic                                inst_push,
    output ife_pkg::queued_inst_t               inst
);
    // Widest instruction the queue entry can carry.
    localparam int INST_BYTES = $bits(ife_pkg::inst_bytes_t) / 8;

    ife_pkg::byte_t     opcode;
    ife_pkg::inst_len_t len;
    logic               defined;
    ife_pkg::addr_t     decode_addr;

    assign opcode = buf_head[0];

    // Length from the opcode class in bits 2..0.
    always_comb begin
        defined = 1'b1;
        case (opcode[2:0])
            // ALU, immediate form is 6 bytes.
            3'b100: len = opcode[3] ? 4'd6 : 4'd2;
            // Memory.
            // Register form is 2, GIO 3, load/store 6.
            3'b010: len = opcode[3] ? 4'd2 : (opcode[4] ? 4'd3 : 4'd6);
            // Program flow, immediate target is 5 bytes.
            3'b110: len = opcode[3] ? 4'd5 : 4'd1;
            default: begin
                // Unknown class, decode stalls until a jump.
                defined = 1'b0;
                len     = '0;
            end
        endcase
    end

    // Whole instruction present and room in the queue.
    assign inst_push   = defined && (buf_count >= ife_pkg::buf_count_t'(len)) && !iq_full;
    assign buf_pop_len = inst_push ? len : '0;

    // Queue entry, bytes past the length read as zero.
    always_comb begin
        inst.bits = '0;
        for (int i = 0; i < INST_BYTES; i++) begin
            if (i < len) begin
                inst.bits[i*8 +: 8] = buf_head[i];
            end
        end
        inst.addr = decode_addr;
        inst.len  = len;
    end

    // Address of the byte at the buffer head.
    always_ff @(posedge clk) begin
        if (reset) begin
            decode_addr <= '0;
        end else if (flush) begin
            decode_addr <= pc;
        end else if (inst_push) begin
            decode_addr <= decode_addr + ife_pkg::addr_t'(len);
        end
    end

endmodule

// File: source/instruction_queue.sv
`timescale 1ns/10ps
`include "ife_cfg.svh"

module instruction_queue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  inst_push,
    input  ife_pkg::queued_inst_t inst,
    input  logic                  iq_pop,
    output ife_pkg::queued_inst_t iq_out,
    output logic                  iq_present,
    output logic                  iq_full
);
    localparam int PTR_W = $clog2(`IFE_IQ_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    ife_pkg::queued_inst_t entries [`IFE_IQ_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  do_pop;

    // Head entry is always on the output.
    assign iq_out     = entries[rd_ptr];
    assign iq_present = count != '0;
    assign iq_full    = count == CNT_W'(`IFE_IQ_DEPTH);

    // Pop only while something is there.
    assign do_pop = iq_pop && iq_present;

    // Entry storage.
    always_ff @(posedge clk) begin
        if (inst_push) begin
            entries[wr_ptr] <= inst;
        end
    end

    // Either a reset or a jump empties the queue.
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (inst_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(inst_push) - CNT_W'(do_pop);
        end
    end

endmodule

// File: source/instruction_front_end.sv
`timescale 1ns/10ps
`include "ife_cfg.svh"

module instruction_front_end (
    input  logic                  clk,
    input  logic                  reset,
    input  ife_pkg::addr_t        pc,
    input  logic                  jump,
    output logic                  mem_req_present,
    output ife_pkg::line_req_t    mem_req,
    input  logic                  mem_req_taken,
    input  logic                  mem_reply_present,
    input  ife_pkg::line_reply_t  mem_reply,
    output ife_pkg::queued_inst_t iq_out,
    output logic                  iq_present,
    input  logic                  iq_pop
);
    // A jump restarts the whole pipe, same as reset.
    logic flush;

    // Fetcher to buffer.
    ife_pkg::byte_mask_t buf_push;
    ife_pkg::line_data_t buf_data;
    ife_pkg::buf_count_t buf_free;

    // Buffer to decoder.
    ife_pkg::byte_t [`IFE_MAX_INST-1:0] buf_head;
    ife_pkg::buf_count_t                buf_count;
    ife_pkg::inst_len_t                 buf_pop_len;

    // Decoder to queue.
    logic                  inst_push;
    ife_pkg::queued_inst_t inst;
    logic                  iq_full;

    assign flush = jump || reset;

    line_fetcher u_fetch (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .pc                (pc),
        .mem_req_present   (mem_req_present),
        .mem_req           (mem_req),
        .mem_req_taken     (mem_req_taken),
        .mem_reply_present (mem_reply_present),
        .mem_reply         (mem_reply),
        .buf_free          (buf_free),
        .buf_push          (buf_push),
        .buf_data          (buf_data)
    );

    byte_buffer u_buf (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .buf_push    (buf_push),
        .buf_data    (buf_data),
        .buf_pop_len (buf_pop_len),
        .buf_head    (buf_head),
        .buf_count   (buf_count),
        .buf_free    (buf_free)
    );

    length_decoder u_dec (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .pc          (pc),
        .buf_head    (buf_head),
        .buf_count   (buf_count),
        .iq_full     (iq_full),
        .buf_pop_len (buf_pop_len),
        .inst_push   (inst_push),
        .inst        (inst)
    );

    instruction_queue u_iq (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .inst_push  (inst_push),
        .inst       (inst),
        .iq_pop     (iq_pop),
        .iq_out     (iq_out),
        .iq_present (iq_present),
        .iq_full    (iq_full)
    );

endmodule

// File: tests/ife_props.sv
`timescale 1ns/10ps
`include "ife_cfg.svh"

module ife_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  jump,
    input logic                  mem_req_present,
    input ife_pkg::line_req_t    mem_req,
    input logic                  mem_req_taken,
    input logic                  mem_reply_present,
    input ife_pkg::queued_inst_t iq_out,
    input logic                  iq_present,
    input logic                  iq_pop
);
    // Failures seen so far, read by the testbench at the end.
    int unsigned    fails = 0;
    // Requests taken by memory and not yet answered, stale ones too.
    int             in_flight;
    // Address the next popped instruction must have.
    ife_pkg::addr_t next_addr;
    logic           have_next;
    // Line the next request must ask for, once a fetch run has started.
    ife_pkg::addr_t next_req;
    logic           have_req;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(mem_req_present && mem_req_taken)
                         - int'(mem_reply_present);
        end
    end

    // A jump starts a new address chain.
    always_ff @(posedge clk) begin
        if (reset || jump) begin
            have_next <= 1'b0;
        end else if (iq_pop && iq_present) begin
            have_next <= 1'b1;
            next_addr <= iq_out.addr + ife_pkg::addr_t'(iq_out.len);
        end
    end

    // Each taken request names the line after the previous one.
    always_ff @(posedge clk) begin
        if (reset || jump) begin
            have_req <= 1'b0;
        end else if (mem_req_present && mem_req_taken) begin
            have_req <= 1'b1;
            next_req <= mem_req.addr + ife_pkg::addr_t'(`IFE_LINE_BYTES);
        end
    end

    reset_quiet: assert property (@(posedge clk) reset |=> !iq_present && !mem_req_present)
        else begin fails++; $error("Queue or request active right after reset"); end

    req_sequence: assert property (@(posedge clk) disable iff (reset)
        mem_req_present && have_req |-> mem_req.addr == next_req)
        else begin fails++; $error("Memory request skips or repeats a line"); end

    // Held request must not change under the memory.
    req_steady: assert property (@(posedge clk) disable iff (reset)
        mem_req_present && !mem_req_taken && !jump |=> mem_req_present && $stable(mem_req))
        else begin fails++; $error("Memory request changed before it was taken"); end

    flight_limit: assert property (@(posedge clk) disable iff (reset)
        in_flight <= `IFE_REQ_DEPTH)
        else begin fails++; $error("Too many line requests in flight"); end

    addr_chain: assert property (@(posedge clk) disable iff (reset)
        iq_pop && iq_present && have_next |-> iq_out.addr == next_addr)
        else begin fails++; $error("Popped address does not follow the previous one"); end

endmodule

bind instruction_front_end ife_props u_props (
    .clk               (clk),
    .reset             (reset),
    .jump              (jump),
    .mem_req_present   (mem_req_present),
    .mem_req           (mem_req),
    .mem_req_taken     (mem_req_taken),
    .mem_reply_present (mem_reply_present),
    .iq_out            (iq_out),
    .iq_present        (iq_present),
    .iq_pop            (iq_pop)
);

// File: tests/ife_tb.sv
`timescale 1ns/10ps

module ife_tb;
    // Planned traffic takes about 5000 cycles.
    localparam int MAX_CYCLES = 20000;

    logic                  clk = 1'b0;
    logic                  reset = 1'b1;
    ife_pkg::addr_t        pc = '0;
    logic                  jump = 1'b0;
    logic                  mem_req_present;
    ife_pkg::line_req_t    mem_req;
    logic                  mem_req_taken = 1'b0;
    logic                  mem_reply_present = 1'b0;
    ife_pkg::line_reply_t  mem_reply = '0;
    ife_pkg::queued_inst_t iq_out;
    logic                  iq_present;
    logic                  iq_pop = 1'b0;

    // Program image, addresses wrap at 4 KiB.
    ife_pkg::byte_t image [4096];
    int             seed = 32'h6a8f_9bdd;
    // Memory timing draws from its own stream.
    int             mem_seed = 32'h6a8f_9bdd;
    int             cycles = 0;
    int             value_errors = 0;
    int             other_errors = 0;
    ife_pkg::addr_t exp_addr = '0;
    ife_pkg::addr_t req_q [$];
    int             due_q [$];
    logic           want_first = 1'b0;
    logic           taken;
    ife_pkg::addr_t undef_at;

    instruction_front_end DUT (
        .clk (clk), .reset (reset), .pc (pc), .jump (jump),
        .mem_req_present (mem_req_present), .mem_req (mem_req),
        .mem_req_taken (mem_req_taken), .mem_reply_present (mem_reply_present),
        .mem_reply (mem_reply), .iq_out (iq_out), .iq_present (iq_present),
        .iq_pop (iq_pop)
    );

    always #50 clk = ~clk;

    // Length table by opcode class, 0 for an undefined class.
    function automatic int legal_len(ife_pkg::byte_t op);
        case (op[2:0])
            3'b100: return op[3] ? 6 : 2;
            3'b010: return op[3] ? 2 : (op[4] ? 3 : 6);
            3'b110: return op[3] ? 5 : 1;
            default: return 0;
        endcase
    endfunction

    function automatic ife_pkg::line_data_t line_at(ife_pkg::addr_t a);
        ife_pkg::line_data_t d;
        for (int i = 0; i < 16; i++) begin
            d[i*8 +: 8] = image[(a + i) & 32'hfff];
        end
        return d;
    endfunction

    task automatic report_mismatch(input string field, input logic [63:0] got,
                                   input logic [63:0] want);
        value_errors++;
        $display("** Error at %0t ns: %s is %0h, expected %0h", $time, field, got, want);
    endtask

    // Random legal instructions from start; last gets the end address.
    task automatic write_program(input ife_pkg::addr_t start, input int count,
                                 output ife_pkg::addr_t last);
        ife_pkg::addr_t a;
        ife_pkg::byte_t op;
        int             len;
        a = start;
        for (int k = 0; k < count; k++) begin
            op = ife_pkg::byte_t'($random(seed));
            case ($unsigned($random(seed)) % 3)
                0: op[2:0] = 3'b100;
                1: op[2:0] = 3'b010;
                default: op[2:0] = 3'b110;
            endcase
            len = legal_len(op);
            image[a[11:0]] = op;
            for (int i = 1; i < len; i++) begin
                image[(a + i) & 32'hfff] = ife_pkg::byte_t'($random(seed));
            end
            a = a + len;
        end
        last = a;
    endtask

    // Compares the queue head with the next instruction of the image walk.
    task automatic check_head();
        int                   len;
        ife_pkg::inst_bytes_t bits;
        len  = legal_len(image[exp_addr[11:0]]);
        bits = '0;
        for (int i = 0; i < len; i++) begin
            bits[i*8 +: 8] = image[(exp_addr + i) & 32'hfff];
        end
        assert (iq_out.addr == exp_addr) else report_mismatch("address", iq_out.addr, exp_addr);
        assert (iq_out.len == len) else report_mismatch("length", iq_out.len, len);
        assert (iq_out.bits == bits) else report_mismatch("bytes", iq_out.bits, bits);
        exp_addr = exp_addr + len;
    endtask

    // Pops count instructions with random stalls.
    task automatic pop_stream(input int count);
        int done;
        done = 0;
        while (done < count) begin
            @(negedge clk);
            if (iq_present && ($unsigned($random(seed)) % 4 != 0)) begin
                check_head();
                iq_pop <= 1'b1;
                done++;
            end else begin
                iq_pop <= 1'b0;
            end
        end
        @(negedge clk);
        iq_pop <= 1'b0;
    endtask

    task automatic do_jump(input ife_pkg::addr_t target);
        @(negedge clk);
        pc       <= target;
        jump     <= 1'b1;
        exp_addr = target;
        @(negedge clk);
        jump <= 1'b0;
    endtask

    // In-order memory, each reply 1 to 4 cycles after its request.
    always @(negedge clk) begin
        if (reset) begin
            mem_req_taken     <= 1'b0;
            mem_reply_present <= 1'b0;
        end else begin
            if (req_q.size() > 0 && due_q[0] <= cycles) begin
                mem_reply_present <= 1'b1;
                mem_reply.addr    <= req_q[0];
                mem_reply.data    <= line_at(req_q[0]);
                void'(req_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                mem_reply_present <= 1'b0;
            end
            // Jump is still high one cycle after it was driven.
            if (jump) begin
                want_first = 1'b1;
            end
            taken = ($unsigned($random(mem_seed)) % 4) != 0;
            mem_req_taken <= taken;
            if (mem_req_present && taken) begin
                if (want_first) begin
                    assert (mem_req.addr == {pc[31:4], 4'h0})
                        else report_mismatch("first request", mem_req.addr, {pc[31:4], 4'h0});
                    want_first = 1'b0;
                end
                req_q.push_back(mem_req.addr);
                due_q.push_back(cycles + 1 + int'($unsigned($random(mem_seed)) % 4));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        for (int i = 0; i < 4096; i++) begin
            image[i] = ife_pkg::byte_t'(i ^ (i >> 4));
        end
        write_program(32'h000, 260, undef_at);
        write_program(32'h805, 100, undef_at);
        write_program(32'hc00, 6, undef_at);
        // Class 111 is undefined.
        image[undef_at[11:0]] = 8'h07;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;

        pop_stream(200);
        do_jump(32'h805);
        pop_stream(40);

        // First jump leaves requests in flight, the second makes them stale.
        do_jump(32'h900);
        do @(posedge clk); while (req_q.size() < 2);
        do_jump(32'h000);
        pop_stream(30);

        // Back-pressure.
        do @(negedge clk); while (!iq_present);
        repeat (100) begin
            @(negedge clk);
            assert (iq_present) else begin
                other_errors++;
                $display("The queue ran empty while pops were held off at %0t ns", $time);
            end
        end
        pop_stream(60);

        do_jump(32'hc00);
        pop_stream(6);
        repeat (50) begin
            @(negedge clk);
            assert (!iq_present) else begin
                other_errors++;
                $display("An instruction appeared past an undefined opcode at %0t ns", $time);
            end
        end
        do_jump(32'h805);
        pop_stream(20);

        $display("Closing counts: %0d value errors, %0d other errors, %0d assertion failures",
                 value_errors, other_errors, DUT.u_props.fails);
        if (value_errors == 0 && other_errors == 0 && DUT.u_props.fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+source
source/ife_pkg.sv
source/line_fetcher.sv
source/byte_buffer.sv
source/length_decoder.sv
source/instruction_queue.sv
source/instruction_front_end.sv
tests/ife_props.sv
tests/ife_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := ife_tb
FILELIST := filelist.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
